//--- Bender.yml
package:
  name: msp430_core

sources:
  - msp430Pkg.sv
  - instrDecoder.sv
  - regFile.sv
  - functionUnit.sv
  - pcUnit.sv
  - msp430Core.sv
  - target: test
    files:
      - msp430Core_asserts.sv
      - tbMsp430Core.sv

//--- functionUnit.sv
//////////////////////////////
// Function unit
// Combinational ALU, result and flags
//////////////////////////////
`timescale 1ns/1ps

module functionUnit
   import msp430Pkg::*;
(
   input  aluFunc_e    aluFunc,
   input  logic [15:0] src,
   input  logic [15:0] dst,
   input  logic [3:0]  flagsIn,
   output logic [15:0] result,
   output logic [3:0]  flagsOut
);

   logic        subtract;
   logic [15:0] addB;
   logic        carryIn;
   logic [16:0] sum;
   logic        addOvf;
   logic        newC;
   logic        newV;
   logic        cNotZ;
   logic        keepFlags;

   always_comb
   begin
      // One adder, subtract as dst + ~src + carry
      subtract = aluFunc inside {FS_SUB, FS_SUBC, FS_CMP};
      addB     = subtract ? ~src : src;
      case (aluFunc)
         FS_ADDC, FS_SUBC: carryIn = flagsIn[FLAG_C];
         FS_SUB, FS_CMP:   carryIn = 1'b1;
         default:          carryIn = 1'b0;
      endcase
      sum    = {1'b0, dst} + {1'b0, addB} + {16'h0000, carryIn};
      // Same-sign operands, different-sign result
      addOvf = (dst[15] == addB[15]) && (sum[15] != dst[15]);

      result = dst;
      newC   = flagsIn[FLAG_C];
      newV   = 1'b0;
      cNotZ  = 1'b0;
      case (aluFunc)
         FS_MOV:
            result = src;
         FS_ADD, FS_ADDC, FS_SUBC, FS_SUB, FS_CMP:
         begin
            result = sum[15:0];
            // Carry out, or no borrow on subtract
            newC   = sum[16];
            newV   = addOvf;
         end
         FS_BIT, FS_AND:
         begin
            result = dst & src;
            cNotZ  = 1'b1;
         end
         FS_XOR:
         begin
            result = dst ^ src;
            cNotZ  = 1'b1;
            newV   = src[15] & dst[15];
         end
         FS_BIC:
            result = dst & ~src;
         FS_BIS:
            result = dst | src;
         FS_RRC:
         begin
            result = {flagsIn[FLAG_C], dst[15:1]};
            newC   = dst[0];
         end
         FS_RRA:
         begin
            result = {dst[15], dst[15:1]};
            newC   = dst[0];
         end
         FS_SWPB:
            result = {dst[7:0], dst[15:8]};
         FS_SXT:
         begin
            result = {{8{dst[7]}}, dst[7:0]};
            cNotZ  = 1'b1;
         end
         default:
            result = dst;
      endcase

      // Moves, bit set/clear and byte swap leave SR alone
      keepFlags = aluFunc inside {FS_MOV, FS_BIC, FS_BIS, FS_SWPB, FS_NOP};
      flagsOut  = flagsIn;
      if (!keepFlags)
      begin
         flagsOut[FLAG_N] = result[15];
         flagsOut[FLAG_Z] = (result == 16'h0000);
         flagsOut[FLAG_C] = cNotZ ? (result != 16'h0000) : newC;
         flagsOut[FLAG_V] = newV;
      end
   end

endmodule

//--- instrDecoder.sv
//////////////////////////////
// Instruction decoder
// Byte swap, format and opcode decode
// Registered execute-stage controls
//////////////////////////////
`timescale 1ns/1ps

module instrDecoder
   import msp430Pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       instrValid,
   input  logic [15:0] instrWord,
   output logic       execValid,
   output aluFunc_e   aluFunc,
   output logic [3:0] srcAddr,
   output logic [3:0] dstAddr,
   output logic       wrReq,
   output logic       flagsReq,
   output logic       isJump,
   output jumpCond_e  jumpCond,
   output logic [9:0] jumpOffset,
   output logic       illegalInstr
);

   logic [15:0]  swapped;
   instrFormat_e fmt;
   aluFunc_e     nextFunc;
   logic         nextWr;
   logic         nextFlags;
   logic         nextBad;

   // Words come off the data bus with bytes swapped
   assign swapped = {instrWord[7:0], instrWord[15:8]};

   always_comb
   begin
      // Jumps are 001x, single-operand 000100
      if (swapped[15:13] == 3'b001)
         fmt = FMT_J;
      else if (swapped[15:10] == 6'b000100)
         fmt = FMT_II;
      else if (swapped[15:12] >= 4'h4)
         fmt = FMT_I;
      else
         fmt = FMT_BAD;

      nextFunc = FS_NOP;
      case (fmt)
         FMT_I:
         begin
            // Register mode only, word only
            if (!swapped[7] && !swapped[6] && swapped[5:4] == 2'b00)
            begin
               case (fmtIOp_e'(swapped[15:12]))
                  OP_MOV:  nextFunc = FS_MOV;
                  OP_ADD:  nextFunc = FS_ADD;
                  OP_ADDC: nextFunc = FS_ADDC;
                  OP_SUBC: nextFunc = FS_SUBC;
                  OP_SUB:  nextFunc = FS_SUB;
                  OP_CMP:  nextFunc = FS_CMP;
                  OP_BIT:  nextFunc = FS_BIT;
                  OP_BIC:  nextFunc = FS_BIC;
                  OP_BIS:  nextFunc = FS_BIS;
                  OP_XOR:  nextFunc = FS_XOR;
                  OP_AND:  nextFunc = FS_AND;
                  // DADD falls through as NOP
                  default: nextFunc = FS_NOP;
               endcase
            end
         end
         FMT_II:
         begin
            if (!swapped[6] && swapped[5:4] == 2'b00)
            begin
               case (fmtIIOp_e'(swapped[9:7]))
                  OP_RRC:  nextFunc = FS_RRC;
                  OP_SWPB: nextFunc = FS_SWPB;
                  OP_RRA:  nextFunc = FS_RRA;
                  OP_SXT:  nextFunc = FS_SXT;
                  // PUSH, CALL, RETI unsupported
                  default: nextFunc = FS_NOP;
               endcase
            end
         end
         default:
            nextFunc = FS_NOP;
      endcase

      // Compares and bit tests only touch flags
      nextWr    = !(nextFunc inside {FS_CMP, FS_BIT, FS_NOP});
      nextFlags = !(nextFunc inside {FS_MOV, FS_BIC, FS_BIS, FS_SWPB, FS_NOP});
      // Anything that is neither a jump nor a known op
      nextBad   = (fmt != FMT_J) && (nextFunc == FS_NOP);
   end

   // Execute-cycle controls, live for one cycle per strobe
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         execValid    <= 1'b0;
         wrReq        <= 1'b0;
         flagsReq     <= 1'b0;
         isJump       <= 1'b0;
         illegalInstr <= 1'b0;
      end
      else
      begin
         execValid    <= instrValid;
         // R0 to R3 are never written
         wrReq        <= instrValid && nextWr && (swapped[3:2] != 2'b00);
         flagsReq     <= instrValid && nextFlags;
         isJump       <= instrValid && (fmt == FMT_J);
         illegalInstr <= instrValid && nextBad;
      end
   end

   // Operand fields, held between strobes
   always_ff @(posedge clk)
   begin
      if (instrValid)
      begin
         aluFunc    <= nextFunc;
         srcAddr    <= (fmt == FMT_I) ? swapped[11:8] : swapped[3:0];
         dstAddr    <= swapped[3:0];
         jumpCond   <= jumpCond_e'(swapped[12:10]);
         jumpOffset <= swapped[9:0];
      end
   end

endmodule

//--- msp430Core.sv
//////////////////////////////
// Core top level
// Decoder, registers, ALU, PC
//////////////////////////////
`timescale 1ns/1ps

module msp430Core
   import msp430Pkg::*;
#(
   parameter logic [15:0] RESET_PC = 16'hC000
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic        instrValid,
   input  logic [15:0] instrWord,
   output logic [15:0] pcOut,
   output logic        regWrEn,
   output logic [3:0]  regWrAddr,
   output logic [15:0] regWrData,
   output logic [3:0]  flags,
   output logic        illegalInstr
);

   aluFunc_e    aluFunc;
   jumpCond_e   jumpCond;
   logic [3:0]  srcAddr;
   logic [9:0]  jumpOffset;
   logic        execValid;
   logic        flagsReq;
   logic        isJump;
   logic [15:0] srcData;
   logic [15:0] dstData;
   logic [3:0]  aluFlags;

   // Write enable already carries valid and R4+ check
   instrDecoder uDecoder
   (
      .clk          (clk),
      .rst          (rst),
      .instrValid   (instrValid),
      .instrWord    (instrWord),
      .execValid    (execValid),
      .aluFunc      (aluFunc),
      .srcAddr      (srcAddr),
      .dstAddr      (regWrAddr),
      .wrReq        (regWrEn),
      .flagsReq     (flagsReq),
      .isJump       (isJump),
      .jumpCond     (jumpCond),
      .jumpOffset   (jumpOffset),
      .illegalInstr (illegalInstr)
   );

   regFile uRegFile
   (
      .clk      (clk),
      .rst      (rst),
      .srcAddr  (srcAddr),
      .dstAddr  (regWrAddr),
      .wrEn     (regWrEn),
      .wrData   (regWrData),
      .flagsEn  (flagsReq),
      .newFlags (aluFlags),
      .srcData  (srcData),
      .dstData  (dstData),
      .flags    (flags)
   );

   functionUnit uFunctionUnit
   (
      .aluFunc  (aluFunc),
      .src      (srcData),
      .dst      (dstData),
      .flagsIn  (flags),
      .result   (regWrData),
      .flagsOut (aluFlags)
   );

   pcUnit #(.RESET_PC(RESET_PC)) uPcUnit
   (
      .clk        (clk),
      .rst        (rst),
      .execValid  (execValid),
      .isJump     (isJump),
      .jumpCond   (jumpCond),
      .jumpOffset (jumpOffset),
      .flags      (flags),
      .pcOut      (pcOut)
   );

endmodule

//--- msp430Core_asserts.sv
//////////////////////////////
// Concurrent checks on the core
// Bound into the top level
//////////////////////////////
`timescale 1ns/1ps

module msp430CoreAsserts
(
   input logic        clk,
   input logic        rst,
   input logic        instrValid,
   input logic [15:0] pcOut,
   input logic        regWrEn,
   input logic [3:0]  regWrAddr,
   input logic        illegalInstr
);

   // Number of failed checks so far
   int failCount = 0;

   // Quiet ports the cycle after a reset edge
   quietAfterReset: assert property (@(posedge clk) rst |=> (!regWrEn && !illegalInstr))
   else
   begin
      failCount++;
      $error("write or illegal flag active right after reset");
   end

   // R0 to R3 never written
   noLowWrite: assert property (@(posedge clk) disable iff (rst)
      regWrEn |-> (regWrAddr >= 4'd4))
   else
   begin
      failCount++;
      $error("register write to R0-R3");
   end

   // PC moves by whole words only at the end of an execute cycle
   pcMoveRule: assert property (@(posedge clk) disable iff (rst)
      (pcOut != $past(pcOut)) |-> ($past(instrValid, 2) && (pcOut[0] == $past(pcOut[0]))))
   else
   begin
      failCount++;
      $error("PC changed without a strobe or by an odd amount");
   end

   noWriteOnIllegal: assert property (@(posedge clk) disable iff (rst)
      !(illegalInstr && regWrEn))
   else
   begin
      failCount++;
      $error("write enable together with illegal instruction");
   end

endmodule

bind msp430Core msp430CoreAsserts uAsserts
(
   .clk          (clk),
   .rst          (rst),
   .instrValid   (instrValid),
   .pcOut        (pcOut),
   .regWrEn      (regWrEn),
   .regWrAddr    (regWrAddr),
   .illegalInstr (illegalInstr)
);

//--- msp430Pkg.sv
//////////////////////////////
// Shared core definitions
// Format, opcode, jump and ALU enums
// Flag bit positions
//////////////////////////////
package msp430Pkg;

   // Instruction class after byte swap
   typedef enum logic [1:0]
   {
      FMT_I,
      FMT_II,
      FMT_J,
      FMT_BAD
   } instrFormat_e;

   // Two-operand opcodes, bits 15:12
   typedef enum logic [3:0]
   {
      OP_MOV  = 4'h4,
      OP_ADD  = 4'h5,
      OP_ADDC = 4'h6,
      OP_SUBC = 4'h7,
      OP_SUB  = 4'h8,
      OP_CMP  = 4'h9,
      // Decimal add, not executed here
      OP_DADD = 4'hA,
      OP_BIT  = 4'hB,
      OP_BIC  = 4'hC,
      OP_BIS  = 4'hD,
      OP_XOR  = 4'hE,
      OP_AND  = 4'hF
   } fmtIOp_e;

   // Single-operand opcodes, bits 9:7
   typedef enum logic [2:0]
   {
      OP_RRC  = 3'd0,
      OP_SWPB = 3'd1,
      OP_RRA  = 3'd2,
      OP_SXT  = 3'd3
   } fmtIIOp_e;

   // Jump conditions, bits 12:10
   typedef enum logic [2:0]
   {
      JNE,
      JEQ,
      JNC,
      JC,
      JN,
      JGE,
      JL,
      JMP
   } jumpCond_e;

   // Function select, decoder to function unit
   typedef enum logic [3:0]
   {
      FS_MOV,
      FS_ADD,
      FS_ADDC,
      FS_SUBC,
      FS_SUB,
      FS_CMP,
      FS_BIT,
      FS_BIC,
      FS_BIS,
      FS_XOR,
      FS_AND,
      FS_RRC,
      FS_SWPB,
      FS_RRA,
      FS_SXT,
      FS_NOP
   } aluFunc_e;

   // Positions in the 4-bit status vector
   localparam int unsigned FLAG_C = 0;
   localparam int unsigned FLAG_Z = 1;
   localparam int unsigned FLAG_N = 2;
   localparam int unsigned FLAG_V = 3;

endpackage

//--- pcUnit.sv
//////////////////////////////
// Program counter
// Jump condition check, PC step
//////////////////////////////
`timescale 1ns/1ps

module pcUnit
   import msp430Pkg::*;
#(
   parameter logic [15:0] RESET_PC = 16'hC000
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic        execValid,
   input  logic        isJump,
   input  jumpCond_e   jumpCond,
   input  logic [9:0]  jumpOffset,
   input  logic [3:0]  flags,
   output logic [15:0] pcOut
);

   logic        condTrue;
   logic [15:0] pcStep;
   logic [15:0] jumpTarget;

   always_comb
   begin
      case (jumpCond)
         JNE:     condTrue = !flags[FLAG_Z];
         JEQ:     condTrue = flags[FLAG_Z];
         JNC:     condTrue = !flags[FLAG_C];
         JC:      condTrue = flags[FLAG_C];
         JN:      condTrue = flags[FLAG_N];
         JGE:     condTrue = (flags[FLAG_N] == flags[FLAG_V]);
         JL:      condTrue = (flags[FLAG_N] != flags[FLAG_V]);
         default: condTrue = 1'b1;
      endcase
   end

   assign pcStep     = pcOut + 16'd2;
   // Signed word offset, relative to PC+2
   assign jumpTarget = pcStep + {{5{jumpOffset[9]}}, jumpOffset, 1'b0};

   always_ff @(posedge clk)
   begin
      if (rst)
         pcOut <= RESET_PC;
      else if (execValid)
         pcOut <= (isJump && condTrue) ? jumpTarget : pcStep;
   end

endmodule

//--- project.f
msp430Pkg.sv
instrDecoder.sv
regFile.sv
functionUnit.sv
pcUnit.sv
msp430Core.sv
msp430Core_asserts.sv
tbMsp430Core.sv

//--- regFile.sv
//////////////////////////////
// Register file
// General registers R4 to R15
// Status flag register
//////////////////////////////
`timescale 1ns/1ps

module regFile
(
   input  logic        clk,
   input  logic        rst,
   input  logic [3:0]  srcAddr,
   input  logic [3:0]  dstAddr,
   input  logic        wrEn,
   input  logic [15:0] wrData,
   input  logic        flagsEn,
   input  logic [3:0]  newFlags,
   output logic [15:0] srcData,
   output logic [15:0] dstData,
   output logic [3:0]  flags
);

   // PC, SP, SR and CG live elsewhere or not at all
   logic [15:0] gpr [4:15];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 4; i < 16; i++)
         begin
            gpr[i] <= 16'h0000;
         end
         flags <= 4'h0;
      end
      else
      begin
         // Commit at the end of the execute cycle
         if (wrEn && dstAddr >= 4'd4)
            gpr[dstAddr] <= wrData;
         if (flagsEn)
            flags <= newFlags;
      end
   end

   // Combinational reads, low registers read as zero
   always_comb
   begin
      if (srcAddr < 4'd4)
         srcData = 16'h0000;
      else
         srcData = gpr[srcAddr];

      if (dstAddr < 4'd4)
         dstData = 16'h0000;
      else
         dstData = gpr[dstAddr];
   end

endmodule

//--- tbMsp430Core.sv
//////////////////////////////
// Core testbench
// Clock, reset, stimulus
// Reference model and checks
//////////////////////////////
`timescale 1ns/1ps

module tbMsp430Core
   import msp430Pkg::*;
();

   localparam logic [15:0] START_PC = 16'hF800;

   logic        clk;
   logic        rst;
   logic        instrValid;
   logic [15:0] instrWord;
   logic [15:0] pcOut;
   logic        regWrEn;
   logic [3:0]  regWrAddr;
   logic [15:0] regWrData;
   logic [3:0]  flags;
   logic        illegalInstr;

   // Reference state with R0 to R3 held at zero
   logic [15:0] regs [0:15];
   logic [3:0]  mFlags;
   logic [15:0] mPc;
   // Instruction strobed last cycle and executing now
   logic        pendValid;
   logic [15:0] pendInstr;
   int          seed = 74;

   msp430Core #(.RESET_PC(START_PC)) dut
   (
      .clk          (clk),
      .rst          (rst),
      .instrValid   (instrValid),
      .instrWord    (instrWord),
      .pcOut        (pcOut),
      .regWrEn      (regWrEn),
      .regWrAddr    (regWrAddr),
      .regWrData    (regWrData),
      .flags        (flags),
      .illegalInstr (illegalInstr)
   );

   always #2 clk = ~clk;

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [15:0] expV, input logic [15:0] gotV);
      assert (gotV === expV)
      else
         abortRun($sformatf("error %s exp %h got %h", name, expV, gotV));
   endtask

   function automatic int pickBelow(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Instruction words in memory order before the bus swap
   function automatic logic [15:0] encodeTwoOp(input int op, input int src, input int dst);
      return {4'(op), 4'(src), 4'b0000, 4'(dst)};
   endfunction

   function automatic logic [15:0] encodeOneOp(input int op, input int dst);
      return {6'b000100, 3'(op), 3'b000, 4'(dst)};
   endfunction

   function automatic logic [15:0] encodeJump(input int cond, input logic [9:0] offset);
      return {3'b001, 3'(cond), offset};
   endfunction

   // Check the executing instruction, then update the model
   task automatic retire();
      logic [15:0] ins;
      logic [15:0] s;
      logic [15:0] d;
      logic [15:0] res;
      logic [16:0] full;
      logic        legal;
      logic        writes;
      logic        setsFlags;
      logic        jump;
      logic        taken;
      logic        cf;
      logic        vf;
      logic        zeroC;
      logic        wrExp;

      if (!pendValid)
      begin
         checkValue("regWrEn", 16'h0, regWrEn);
         checkValue("illegalInstr", 16'h0, illegalInstr);
         return;
      end
      ins = pendInstr;
      s = regs[ins[11:8]];
      d = regs[ins[3:0]];
      legal = 1'b1;
      writes = 1'b1;
      setsFlags = 1'b1;
      jump = 1'b0;
      taken = 1'b0;
      res = d;
      cf = 1'b0;
      vf = 1'b0;
      zeroC = 1'b0;
      if (ins[15:13] == 3'b001)
      begin
         jump = 1'b1;
         writes = 1'b0;
         setsFlags = 1'b0;
         case (ins[12:10])
            3'd0: taken = !mFlags[FLAG_Z];
            3'd1: taken = mFlags[FLAG_Z];
            3'd2: taken = !mFlags[FLAG_C];
            3'd3: taken = mFlags[FLAG_C];
            3'd4: taken = mFlags[FLAG_N];
            3'd5: taken = mFlags[FLAG_N] ~^ mFlags[FLAG_V];
            3'd6: taken = mFlags[FLAG_N] ^ mFlags[FLAG_V];
            default: taken = 1'b1;
         endcase
      end
      else if (ins[15:10] == 6'b000100)
      begin
         // Single operand in register mode with word size only
         legal = (ins[6:4] == 3'b000) && (ins[9:7] < 3'd4);
         case (ins[9:7])
            3'd0:
            begin
               res = {mFlags[FLAG_C], d[15:1]};
               cf = d[0];
            end
            3'd1:
            begin
               res = {d[7:0], d[15:8]};
               setsFlags = 1'b0;
            end
            3'd2:
            begin
               res = {d[15], d[15:1]};
               cf = d[0];
            end
            3'd3:
            begin
               res = {{8{d[7]}}, d[7:0]};
               zeroC = 1'b1;
            end
            default: res = d;
         endcase
      end
      else if (ins[15:12] >= 4'h4)
      begin
         legal = (ins[7:4] == 4'h0) && (ins[15:12] != 4'hA);
         case (ins[15:12])
            4'h4:
            begin
               res = s;
               setsFlags = 1'b0;
            end
            4'h5, 4'h6:
            begin
               full = {1'b0, d} + {1'b0, s} + ((ins[15:12] == 4'h6) ? mFlags[FLAG_C] : 1'b0);
               res = full[15:0];
               cf = full[16];
               vf = (d[15] == s[15]) && (res[15] != d[15]);
            end
            4'h7, 4'h8, 4'h9:
            begin
               // Borrow form with C set when nothing is borrowed
               full = {1'b0, d} + {1'b0, ~s} + ((ins[15:12] == 4'h7) ? mFlags[FLAG_C] : 1'b1);
               res = full[15:0];
               cf = full[16];
               vf = (d[15] != s[15]) && (res[15] != d[15]);
               writes = (ins[15:12] != 4'h9);
            end
            4'hB:
            begin
               res = d & s;
               zeroC = 1'b1;
               writes = 1'b0;
            end
            4'hC:
            begin
               res = d & ~s;
               setsFlags = 1'b0;
            end
            4'hD:
            begin
               res = d | s;
               setsFlags = 1'b0;
            end
            4'hE:
            begin
               res = d ^ s;
               zeroC = 1'b1;
               vf = s[15] & d[15];
            end
            4'hF:
            begin
               res = d & s;
               zeroC = 1'b1;
            end
            default: res = d;
         endcase
      end
      else
         legal = 1'b0;

      if (!legal)
      begin
         writes = 1'b0;
         setsFlags = 1'b0;
      end
      wrExp = writes && (ins[3:0] >= 4'd4);
      checkValue("illegalInstr", !legal, illegalInstr);
      checkValue("regWrEn", wrExp, regWrEn);
      if (wrExp)
      begin
         checkValue("regWrAddr", ins[3:0], regWrAddr);
         checkValue("regWrData", res, regWrData);
         regs[ins[3:0]] = res;
      end
      if (setsFlags)
      begin
         mFlags[FLAG_N] = res[15];
         mFlags[FLAG_Z] = (res == 16'h0000);
         mFlags[FLAG_C] = zeroC ? (res != 16'h0000) : cf;
         mFlags[FLAG_V] = vf;
      end
      if (jump && taken)
         mPc = mPc + 16'd2 + {{5{ins[9]}}, ins[9:0], 1'b0};
      else
         mPc = mPc + 16'd2;
   endtask

   // Check state, then drive the next word 1 ns after the edge
   task automatic runCycle(input logic valid, input logic [15:0] ins);
      checkValue("pcOut", mPc, pcOut);
      checkValue("flags", mFlags, flags);
      retire();
      instrValid = valid;
      instrWord = {ins[7:0], ins[15:8]};
      pendValid = valid;
      pendInstr = ins;
      @(posedge clk);
      #1;
      // Bound checks on the core evaluate at the edge just passed
      if (dut.uAsserts.failCount != 0)
         abortRun("a bound assertion on the core failed");
   endtask

   // Clear, then shift in bits with ADD and a carry-in add
   task automatic loadRegister(input int r, input logic [15:0] v);
      runCycle(1'b1, encodeTwoOp(4, 3, r));
      for (int b = 15; b >= 0; b--)
      begin
         runCycle(1'b1, encodeTwoOp(5, r, r));
         if (v[b])
         begin
            runCycle(1'b1, encodeTwoOp(9, 3, 3));
            runCycle(1'b1, encodeTwoOp(6, 3, r));
         end
      end
   endtask

   task automatic waitForReset();
      int cycles;

      cycles = 0;
      while (!(pcOut === START_PC && flags === 4'h0 && regWrEn === 1'b0))
      begin
         if (cycles == 20)
            abortRun("core did not reach its reset state in time");
         cycles++;
         @(posedge clk);
         #1;
      end
   endtask

   initial
   begin
      logic [3:0] twoOps [0:10];
      logic [9:0] offset;

      twoOps = '{4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'h9, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
      clk = 1'b0;
      rst = 1'b1;
      instrValid = 1'b0;
      instrWord = 16'h0000;
      for (int i = 0; i < 16; i++)
         regs[i] = 16'h0000;
      mFlags = 4'h0;
      mPc = START_PC;
      pendValid = 1'b0;
      pendInstr = 16'h0000;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      waitForReset();

      // Known values in R4 to R15
      for (int r = 4; r < 16; r++)
         loadRegister(r, 16'($random(seed)));

      // Random two-operand ops with some idle gaps
      for (int n = 0; n < 240; n++)
      begin
         if (n % 40 == 39)
            loadRegister(4 + pickBelow(12), 16'($random(seed)));
         runCycle(1'b1, encodeTwoOp(twoOps[pickBelow(11)], 3 + pickBelow(13), 4 + pickBelow(12)));
         if (pickBelow(4) == 0)
            runCycle(1'b0, 16'h0000);
      end

      // Single-operand ops
      for (int n = 0; n < 80; n++)
      begin
         if (n % 20 == 0)
            loadRegister(4 + pickBelow(12), 16'($random(seed)));
         runCycle(1'b1, encodeOneOp(pickBelow(4), 4 + pickBelow(12)));
      end

      // Each condition against Z=C=1 and against N=1 with C=Z=V=0
      for (int c = 0; c < 8; c++)
      begin
         for (int st = 0; st < 2; st++)
         begin
            runCycle(1'b1, encodeTwoOp(4, 3, 5));
            runCycle(1'b1, encodeTwoOp(9, 3, 3));
            if (st == 1)
               runCycle(1'b1, encodeOneOp(0, 5));
            offset = 10'($random(seed));
            offset[9] = c[0] ^ st[0];
            runCycle(1'b1, encodeJump(c, offset));
         end
      end

      // Dependent chain on consecutive cycles
      runCycle(1'b1, encodeTwoOp(4, 3, 6));
      runCycle(1'b1, encodeTwoOp(9, 3, 3));
      runCycle(1'b1, encodeTwoOp(6, 3, 6));
      runCycle(1'b1, encodeTwoOp(5, 6, 6));
      runCycle(1'b1, encodeTwoOp(5, 6, 7));
      runCycle(1'b1, encodeTwoOp(4'hE, 7, 8));
      runCycle(1'b1, encodeTwoOp(8, 8, 9));
      runCycle(1'b1, encodeOneOp(2, 9));

      // Unsupported modes and opcodes, then low destinations
      runCycle(1'b1, encodeTwoOp(4, 5, 6) | 16'h0080);
      runCycle(1'b1, encodeTwoOp(5, 5, 6) | 16'h0010);
      runCycle(1'b1, encodeTwoOp(5, 5, 6) | 16'h0040);
      runCycle(1'b1, encodeTwoOp(4'hA, 5, 6));
      runCycle(1'b1, encodeOneOp(4, 6));
      runCycle(1'b1, encodeOneOp(6, 0));
      runCycle(1'b1, encodeOneOp(0, 6) | 16'h0040);
      runCycle(1'b1, 16'h0000);
      runCycle(1'b1, encodeTwoOp(5, 6, 2));
      runCycle(1'b1, encodeTwoOp(4, 7, 0));
      runCycle(1'b1, encodeOneOp(2, 1));
      runCycle(1'b0, 16'h0000);
      runCycle(1'b0, 16'h0000);

      if (dut.uAsserts.failCount != 0)
         abortRun("bound assertions on the core failed");
      else
      begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule
